// File: rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

  localparam int XLEN       = 32;
  localparam int MUL_PASSES = 4;   // 8-bit slices of the multiplier operand
  localparam int DIV_STEPS  = 16;  // Two quotient bits per step
  localparam int MUL_CNT_W  = $clog2(MUL_PASSES);
  localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SRL    = 5'd3,
    ALU_SRA    = 5'd4,
    ALU_OR     = 5'd5,
    ALU_AND    = 5'd6,
    ALU_XOR    = 5'd7,
    ALU_SLT    = 5'd8,
    ALU_SLTU   = 5'd9,
    ALU_MUL    = 5'd10,  // Multi-cycle functions start here
    ALU_MULH   = 5'd11,
    ALU_MULHSU = 5'd12,
    ALU_MULHU  = 5'd13,
    ALU_DIV    = 5'd14,
    ALU_DIVU   = 5'd15,
    ALU_REM    = 5'd16,
    ALU_REMU   = 5'd17
  } alu_fn_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_e;

  // Operation word driven by the caller
  typedef struct packed {
    alu_fn_e  fn;
    logic     br_en;    // Evaluate br_cond on the subtractor
    br_cond_e br_cond;
  } alu_op_t;

endpackage

`default_nettype wire

// File: alu_shifter.sv
`default_nettype none

module alu_shifter (
  input  logic [rv_alu_pkg::XLEN-1:0] din,
  input  logic [4:0]                  shamt,
  input  logic                        right,
  input  logic                        arith,
  output logic [rv_alu_pkg::XLEN-1:0] dout
);

  logic [rv_alu_pkg::XLEN-1:0] rev_in;
  logic [rv_alu_pkg::XLEN-1:0] rev_out;
  logic [rv_alu_pkg::XLEN-1:0] stage [0:5];
  logic                        fill;

  // Left shifts run through the right-shift stages on reversed bits
  for (genvar j = 0; j < rv_alu_pkg::XLEN; j++) begin : g_rev
    assign rev_in[j]  = din[rv_alu_pkg::XLEN-1-j];
    assign rev_out[j] = stage[5][rv_alu_pkg::XLEN-1-j];
  end

  assign fill     = arith & right & din[rv_alu_pkg::XLEN-1];
  assign stage[0] = right ? din : rev_in;

  // Stage i shifts by 2**i
  for (genvar i = 0; i < 5; i++) begin : g_stage
    assign stage[i+1] = shamt[i] ?
                        {{(2**i){fill}}, stage[i][rv_alu_pkg::XLEN-1:2**i]} :
                        stage[i];
  end

  assign dout = right ? stage[5] : rev_out;

endmodule

`default_nettype wire

// File: alu_multiplier.sv
`default_nettype none

module alu_multiplier (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          start,
  input  logic                          a_signed,
  input  logic                          b_signed,
  input  logic [rv_alu_pkg::XLEN-1:0]   a,
  input  logic [rv_alu_pkg::XLEN-1:0]   b,
  output logic [2*rv_alu_pkg::XLEN-1:0] prod,
  output logic                          last
);

  logic                              busy;
  logic [rv_alu_pkg::MUL_CNT_W-1:0]  cnt;
  logic [2*rv_alu_pkg::XLEN-1:0]     acc;
  logic signed [rv_alu_pkg::XLEN:0]  a_ext;
  logic signed [8:0]                 slice;
  logic signed [rv_alu_pkg::XLEN+9:0] pp;
  logic [2*rv_alu_pkg::XLEN-1:0]     pp_ext;

  assign a_ext = {a_signed & a[rv_alu_pkg::XLEN-1], a};

  // Only the top slice carries the sign of b
  always_comb begin
    slice[7:0] = b[{cnt, 3'b000} +: 8];
    slice[8]   = b_signed && (cnt == rv_alu_pkg::MUL_PASSES - 1) && slice[7];
  end

  assign pp     = a_ext * slice;
  assign pp_ext = {{(rv_alu_pkg::XLEN-10){pp[rv_alu_pkg::XLEN+9]}}, pp} << {cnt, 3'b000};

  // Dropping start abandons the product
  always_ff @(posedge clk) begin
    if (!rstn || !start)
    begin
      busy <= 1'b0;
      cnt  <= '0;
      last <= 1'b0;
    end
    else if (!busy)
    begin
      busy <= 1'b1;  // Load cycle
    end
    else if (!last)
    begin
      cnt  <= cnt + 1'b1;
      last <= (cnt == rv_alu_pkg::MUL_PASSES - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy)
    begin
      acc <= '0;
    end
    else if (busy && !last)
    begin
      acc <= acc + pp_ext;
    end
  end

  assign prod = acc;  // Held while last stays high

  // Slices of b are summed against a single value of a
  a_held_in_op : assert property (@(posedge clk) disable iff (!rstn)
    start && busy |-> $stable(a));

endmodule

`default_nettype wire

// File: alu_divider.sv
`default_nettype none

module alu_divider (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start,
  input  logic                        is_signed,
  input  logic [rv_alu_pkg::XLEN-1:0] dividend,
  input  logic [rv_alu_pkg::XLEN-1:0] divisor,
  output logic [rv_alu_pkg::XLEN-1:0] quot,
  output logic [rv_alu_pkg::XLEN-1:0] rem,
  output logic                        last
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_STEP,
    S_FIX,
    S_HOLD
  } div_state_e;

  div_state_e                       state;
  logic [rv_alu_pkg::DIV_CNT_W-1:0] step;

  logic [rv_alu_pkg::XLEN-1:0] q_reg;  // Shifts dividend out, quotient in
  logic [rv_alu_pkg::XLEN-1:0] r_reg;
  logic [rv_alu_pkg::XLEN-1:0] d_reg;
  logic                        q_neg;
  logic                        r_neg;
  logic                        div_zero;

  logic                        dvd_neg;
  logic                        dvs_neg;
  logic [rv_alu_pkg::XLEN-1:0] dvd_abs;
  logic [rv_alu_pkg::XLEN-1:0] dvs_abs;

  logic [rv_alu_pkg::XLEN+2:0] r4;
  logic [rv_alu_pkg::XLEN+2:0] d1;
  logic [rv_alu_pkg::XLEN+2:0] d2;
  logic [rv_alu_pkg::XLEN+2:0] d3;
  logic [rv_alu_pkg::XLEN+2:0] t1;
  logic [rv_alu_pkg::XLEN+2:0] t2;
  logic [rv_alu_pkg::XLEN+2:0] t3;
  logic [1:0]                  qd;
  logic [rv_alu_pkg::XLEN-1:0] r_nx;

  assign dvd_neg = is_signed & dividend[rv_alu_pkg::XLEN-1];
  assign dvs_neg = is_signed & divisor[rv_alu_pkg::XLEN-1];
  assign dvd_abs = dvd_neg ? -dividend : dividend;
  assign dvs_abs = dvs_neg ? -divisor : divisor;

  // Radix-4 restoring step, partial remainder is always below d_reg
  always_comb begin
    r4 = {1'b0, r_reg, q_reg[rv_alu_pkg::XLEN-1 -: 2]};
    d1 = {3'b000, d_reg};
    d2 = {2'b00, d_reg, 1'b0};
    d3 = d1 + d2;
    t1 = r4 - d1;
    t2 = r4 - d2;
    t3 = r4 - d3;
    if (!t3[rv_alu_pkg::XLEN+2])
    begin
      qd   = 2'd3;
      r_nx = t3[rv_alu_pkg::XLEN-1:0];
    end
    else if (!t2[rv_alu_pkg::XLEN+2])
    begin
      qd   = 2'd2;
      r_nx = t2[rv_alu_pkg::XLEN-1:0];
    end
    else if (!t1[rv_alu_pkg::XLEN+2])
    begin
      qd   = 2'd1;
      r_nx = t1[rv_alu_pkg::XLEN-1:0];
    end
    else
    begin
      qd   = 2'd0;
      r_nx = r4[rv_alu_pkg::XLEN-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || !start)
    begin
      state <= S_IDLE;
      step  <= '0;
    end
    else
    begin
      case (state)
        S_IDLE: state <= S_STEP;  // Operands latched this edge
        S_STEP:
        begin
          step <= step + 1'b1;
          if (step == rv_alu_pkg::DIV_STEPS - 1)
            state <= S_FIX;
        end
        S_FIX:  state <= S_HOLD;
        default: state <= S_HOLD;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE)
    begin
      q_reg    <= dvd_abs;
      r_reg    <= '0;
      d_reg    <= dvs_abs;
      q_neg    <= dvd_neg ^ dvs_neg;
      r_neg    <= dvd_neg;  // Remainder takes the dividend sign
      div_zero <= (divisor == '0);
    end
    else if (state == S_STEP)
    begin
      q_reg <= {q_reg[rv_alu_pkg::XLEN-3:0], qd};
      r_reg <= r_nx;
    end
    else if (state == S_FIX)
    begin
      // Most negative over -1 lands here as 2**31 with no negation,
      // which is the dividend itself, and a zero remainder
      quot <= div_zero ? '1 : (q_neg ? -q_reg : q_reg);
      rem  <= div_zero ? dividend : (r_neg ? -r_reg : r_reg);
    end
  end

  assign last = (state == S_HOLD);

  divisor_held_in_op : assert property (@(posedge clk) disable iff (!rstn)
    start && state != S_IDLE |-> $stable(divisor));

endmodule

`default_nettype wire

// File: rv_alu.sv
`default_nettype none

module rv_alu (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [rv_alu_pkg::XLEN-1:0] a,
  input  logic [rv_alu_pkg::XLEN-1:0] b,
  input  rv_alu_pkg::alu_op_t         op,
  output logic [rv_alu_pkg::XLEN-1:0] result,
  output logic                        br_taken,
  output logic                        done
);

  logic                          is_sub;
  logic                          uns;
  logic [rv_alu_pkg::XLEN:0]     sum;
  logic                          lt;
  logic                          zero;
  logic [rv_alu_pkg::XLEN-1:0]   sft_out;

  logic                          is_mul;
  logic                          is_div;
  logic                          was_multi;
  logic                          kill;
  logic                          mul_start;
  logic                          div_start;
  logic                          a_signed;
  logic                          b_signed;
  logic                          div_signed;
  logic [2*rv_alu_pkg::XLEN-1:0] prod;
  logic                          mul_last;
  logic [rv_alu_pkg::XLEN-1:0]   quot;
  logic [rv_alu_pkg::XLEN-1:0]   rem;
  logic                          div_last;
  rv_alu_pkg::alu_op_t           op_q;
  logic                          done_flag;

  // Shared 33-bit adder whose extension bit follows signedness
  assign is_sub = op.fn inside {rv_alu_pkg::ALU_SUB, rv_alu_pkg::ALU_SLT,
                                rv_alu_pkg::ALU_SLTU};
  assign uns    = (op.fn == rv_alu_pkg::ALU_SLTU) ||
                  (op.br_en && op.br_cond inside {rv_alu_pkg::BR_LTU, rv_alu_pkg::BR_GEU});
  assign sum    = {~uns & a[rv_alu_pkg::XLEN-1], a} +
                  ({(rv_alu_pkg::XLEN+1){is_sub}} ^ {~uns & b[rv_alu_pkg::XLEN-1], b}) +
                  {{rv_alu_pkg::XLEN{1'b0}}, is_sub};
  assign lt     = sum[rv_alu_pkg::XLEN];
  assign zero   = (sum[rv_alu_pkg::XLEN-1:0] == '0);

  always_comb begin
    case (op.br_cond)
      rv_alu_pkg::BR_EQ:                    br_taken = op.br_en & zero;
      rv_alu_pkg::BR_NE:                    br_taken = op.br_en & ~zero;
      rv_alu_pkg::BR_LT, rv_alu_pkg::BR_LTU: br_taken = op.br_en & lt;
      rv_alu_pkg::BR_GE, rv_alu_pkg::BR_GEU: br_taken = op.br_en & ~lt;
      default:                              br_taken = 1'b0;
    endcase
  end

  alu_shifter shifter_i (
    .din   (a),
    .shamt (b[4:0]),
    .right (op.fn inside {rv_alu_pkg::ALU_SRL, rv_alu_pkg::ALU_SRA}),
    .arith (op.fn == rv_alu_pkg::ALU_SRA),
    .dout  (sft_out)
  );

  // A change of op under a running unit drops its start for one cycle
  assign is_mul    = op.fn inside {[rv_alu_pkg::ALU_MUL : rv_alu_pkg::ALU_MULHU]};
  assign is_div    = op.fn inside {[rv_alu_pkg::ALU_DIV : rv_alu_pkg::ALU_REMU]};
  assign was_multi = op_q.fn inside {[rv_alu_pkg::ALU_MUL : rv_alu_pkg::ALU_REMU]};
  assign kill      = was_multi && (op != op_q);
  assign mul_start = is_mul && !kill;
  assign div_start = is_div && !kill;

  assign a_signed   = (op.fn != rv_alu_pkg::ALU_MULHU);
  assign b_signed   = op.fn inside {rv_alu_pkg::ALU_MUL, rv_alu_pkg::ALU_MULH};
  assign div_signed = op.fn inside {rv_alu_pkg::ALU_DIV, rv_alu_pkg::ALU_REM};

  alu_multiplier multiplier_i (
    .clk      (clk),
    .rstn     (rstn),
    .start    (mul_start),
    .a_signed (a_signed),
    .b_signed (b_signed),
    .a        (a),
    .b        (b),
    .prod     (prod),
    .last     (mul_last)
  );

  alu_divider divider_i (
    .clk       (clk),
    .rstn      (rstn),
    .start     (div_start),
    .is_signed (div_signed),
    .dividend  (a),
    .divisor   (b),
    .quot      (quot),
    .rem       (rem),
    .last      (div_last)
  );

  always_ff @(posedge clk) begin
    if (!rstn)
    begin
      op_q      <= '0;
      done_flag <= 1'b0;
    end
    else
    begin
      op_q <= op;
      if (done)
        done_flag <= 1'b1;
      else if (!mul_start && !div_start)
        done_flag <= 1'b0;  // Armed again once the op goes away
    end
  end

  assign done = ((mul_last && mul_start) || (div_last && div_start)) && !done_flag;

  always_comb begin
    case (op.fn)
      rv_alu_pkg::ALU_ADD,
      rv_alu_pkg::ALU_SUB:    result = sum[rv_alu_pkg::XLEN-1:0];
      rv_alu_pkg::ALU_SLL,
      rv_alu_pkg::ALU_SRL,
      rv_alu_pkg::ALU_SRA:    result = sft_out;
      rv_alu_pkg::ALU_OR:     result = a | b;
      rv_alu_pkg::ALU_AND:    result = a & b;
      rv_alu_pkg::ALU_XOR:    result = a ^ b;
      rv_alu_pkg::ALU_SLT,
      rv_alu_pkg::ALU_SLTU:   result = {{(rv_alu_pkg::XLEN-1){1'b0}}, lt};
      rv_alu_pkg::ALU_MUL:    result = prod[rv_alu_pkg::XLEN-1:0];
      rv_alu_pkg::ALU_MULH,
      rv_alu_pkg::ALU_MULHSU,
      rv_alu_pkg::ALU_MULHU:  result = prod[2*rv_alu_pkg::XLEN-1:rv_alu_pkg::XLEN];
      rv_alu_pkg::ALU_DIV,
      rv_alu_pkg::ALU_DIVU:   result = quot;
      rv_alu_pkg::ALU_REM,
      rv_alu_pkg::ALU_REMU:   result = rem;
      default:                result = '0;
    endcase
  end

  // Branches are only evaluated on a subtracting function
  br_on_subtract : assert property (@(posedge clk) disable iff (!rstn)
    op.br_en |-> op.fn inside {rv_alu_pkg::ALU_SUB, rv_alu_pkg::ALU_SLT,
                               rv_alu_pkg::ALU_SLTU});

endmodule

`default_nettype wire

// File: tb_rv_alu_tests.svh
  task automatic test_single();
    int                  err_start;
    logic [31:0]         x;
    logic [31:0]         y;
    rv_alu_pkg::alu_fn_e fn;
    err_start = err_cnt;
    for (int f = 0; f < 10; f++)
    begin
      fn = rv_alu_pkg::alu_fn_e'(f);
      for (int k = 0; k < NUM_EDGE * NUM_EDGE + RAND_SINGLE; k++)
      begin
        x = (k < NUM_EDGE * NUM_EDGE) ? edge_val(k / NUM_EDGE) : $random(seed);
        y = (k < NUM_EDGE * NUM_EDGE) ? edge_val(k % NUM_EDGE) : $random(seed);
        drive(x, y, make_op(fn, 1'b0, rv_alu_pkg::BR_EQ));
        #(CLK_PERIOD / 4);
        if (result !== ref_result(fn, x, y))
          report_mismatch(fn.name(), x, y, result, ref_result(fn, x, y));
      end
    end
    end_test("single-cycle functions", err_start, OPS_SINGLE);
  endtask

  // Every corner pair gives equal, less and greater cases both ways
  task automatic test_branch();
    int                   err_start;
    logic [31:0]          x;
    logic [31:0]          y;
    rv_alu_pkg::br_cond_e cond;
    err_start = err_cnt;
    for (int c = 0; c < 6; c++)
    begin
      cond = rv_alu_pkg::br_cond_e'(c);
      for (int k = 0; k < NUM_EDGE * NUM_EDGE; k++)
      begin
        x = edge_val(k / NUM_EDGE);
        y = edge_val(k % NUM_EDGE);
        drive(x, y, make_op(rv_alu_pkg::ALU_SUB, 1'b1, cond));
        #(CLK_PERIOD / 4);
        if (br_taken !== ref_branch(cond, x, y))
          report_mismatch(cond.name(), x, y, {31'b0, br_taken}, {31'b0, ref_branch(cond, x, y)});
      end
    end
    end_test("branch conditions", err_start, OPS_BRANCH);
  endtask

  task automatic test_mul();
    int          err_start;
    logic [31:0] x;
    logic [31:0] y;
    err_start = err_cnt;
    for (int f = rv_alu_pkg::ALU_MUL; f <= rv_alu_pkg::ALU_MULHU; f++)
    begin
      for (int k = 0; k < NUM_EDGE * NUM_EDGE + RAND_MUL; k++)
      begin
        x = (k < NUM_EDGE * NUM_EDGE) ? edge_val(k / NUM_EDGE) : $random(seed);
        y = (k < NUM_EDGE * NUM_EDGE) ? edge_val(k % NUM_EDGE) : $random(seed);
        run_multi(rv_alu_pkg::alu_fn_e'(f), x, y, MUL_LAT);
      end
    end
    end_test("multiply", err_start, OPS_MUL);
  endtask

  task automatic test_div();
    int          err_start;
    logic [31:0] x;
    logic [31:0] y;
    err_start = err_cnt;
    for (int f = rv_alu_pkg::ALU_DIV; f <= rv_alu_pkg::ALU_REMU; f++)
    begin
      for (int k = 0; k < RAND_DIV; k++)
      begin
        x = $random(seed);
        y = $random(seed);
        if (k % 2 == 1)
          y = y & 32'h0000_ffff;  // Small divisors give large quotients
        run_multi(rv_alu_pkg::alu_fn_e'(f), x, y, DIV_LAT);
      end
    end
    end_test("divide", err_start, OPS_DIV);
  endtask

  task automatic test_div_special();
    int err_start;
    err_start = err_cnt;
    for (int f = rv_alu_pkg::ALU_DIV; f <= rv_alu_pkg::ALU_REMU; f++)
    begin
      for (int k = 0; k < 5; k++)
        run_multi(rv_alu_pkg::alu_fn_e'(f), edge_val(k + 1), 32'h0, DIV_LAT);
      run_multi(rv_alu_pkg::alu_fn_e'(f), 32'h8000_0000, 32'hffff_ffff, DIV_LAT);
    end
    end_test("divide special cases", err_start, OPS_SPECIAL);
  endtask

  task automatic test_reset_pulse();
    int          err_start;
    int          cycles;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] held;
    err_start = err_cnt;
    x = $random(seed);
    y = $random(seed);
    // Reset arrives one cycle before the multiply would finish
    drive(x, y, make_op(rv_alu_pkg::ALU_MULH, 1'b0, rv_alu_pkg::BR_EQ));
    repeat (MUL_LAT - 1) @(negedge clk);
    rstn = 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      if (done !== 1'b0)
        report_mismatch("done in reset", x, y, {31'b0, done}, 32'h0);
    end
    rstn = 1'b1;
    wait_done(cycles);
    if (cycles != 0 && cycles != MUL_LAT)
    begin
      $display("ERR %0t: done after %0d cycles from reset, expected %0d", $time, cycles, MUL_LAT);
      err_cnt++;
    end
    held = ref_result(rv_alu_pkg::ALU_MULH, x, y);
    repeat (4)
    begin
      @(negedge clk);
      if (done !== 1'b0)
        report_mismatch("done repeated", x, y, {31'b0, done}, 32'h0);
      if (result !== held)
        report_mismatch("held result", x, y, result, held);
    end
    drive('0, '0, idle_op());
    run_multi(rv_alu_pkg::ALU_DIV, x, y, DIV_LAT);
    run_multi(rv_alu_pkg::ALU_MULHU, y, x, MUL_LAT);
    end_test("reset and single pulse", err_start, OPS_PULSE);
  endtask

// File: tb_rv_alu.sv
`default_nettype none

module tb_rv_alu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 20;
  localparam int MUL_LAT     = rv_alu_pkg::MUL_PASSES + 1;  // Load cycle then the passes
  localparam int DIV_LAT     = rv_alu_pkg::DIV_STEPS + 2;
  localparam int NUM_EDGE    = 6;
  localparam int RAND_SINGLE = 16;
  localparam int RAND_MUL    = 8;
  localparam int RAND_DIV    = 12;
  localparam int OPS_SINGLE  = 10 * (NUM_EDGE * NUM_EDGE + RAND_SINGLE);
  localparam int OPS_BRANCH  = 6 * NUM_EDGE * NUM_EDGE;
  localparam int OPS_MUL     = 4 * (NUM_EDGE * NUM_EDGE + RAND_MUL);
  localparam int OPS_DIV     = 4 * RAND_DIV;
  localparam int OPS_SPECIAL = 4 * 5 + 4;
  localparam int OPS_PULSE   = 3;
  localparam int TIMEOUT_CYCLES = (OPS_SINGLE + OPS_BRANCH + OPS_MUL + OPS_DIV + OPS_SPECIAL +
                                   OPS_PULSE) * (rv_alu_pkg::DIV_STEPS + 4) + 200;

  logic                        clk;
  logic                        rstn;
  logic [rv_alu_pkg::XLEN-1:0] a;
  logic [rv_alu_pkg::XLEN-1:0] b;
  rv_alu_pkg::alu_op_t         op;
  logic [rv_alu_pkg::XLEN-1:0] result;
  logic                        br_taken;
  logic                        done;

  integer seed = 32'heed32fc4;
  int     err_cnt;
  int     test_cnt;
  int     cycle_cnt;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_alu rv_alu_i (
    .clk      (clk),
    .rstn     (rstn),
    .a        (a),
    .b        (b),
    .op       (op),
    .result   (result),
    .br_taken (br_taken),
    .done     (done)
  );

  function automatic rv_alu_pkg::alu_op_t make_op(rv_alu_pkg::alu_fn_e fn, logic br_en,
                                                  rv_alu_pkg::br_cond_e cond);
    rv_alu_pkg::alu_op_t o;
    o.fn      = fn;
    o.br_en   = br_en;
    o.br_cond = cond;
    return o;
  endfunction

  function automatic rv_alu_pkg::alu_op_t idle_op();
    return make_op(rv_alu_pkg::ALU_ADD, 1'b0, rv_alu_pkg::BR_EQ);
  endfunction

  // Corner operands including a shift by 31
  function automatic logic [31:0] edge_val(int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h0000_001f;
      3:       return 32'h7fff_ffff;
      4:       return 32'h8000_0000;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic [31:0] ref_result(rv_alu_pkg::alu_fn_e fn, logic [31:0] x,
                                             logic [31:0] y);
    logic [63:0]        p_ss;
    logic [63:0]        p_su;
    logic [63:0]        p_uu;
    logic               ovf;
    logic signed [31:0] q_s;
    logic signed [31:0] r_s;
    p_ss = {{32{x[31]}}, x} * {{32{y[31]}}, y};
    p_su = {{32{x[31]}}, x} * {32'b0, y};
    p_uu = {32'b0, x} * {32'b0, y};
    ovf  = (x == 32'h8000_0000) && (y == 32'hffff_ffff);  // Most negative over -1
    q_s  = '0;
    r_s  = '0;
    if (y != 0 && !ovf)
    begin
      q_s = $signed(x) / $signed(y);  // Truncates toward zero
      r_s = $signed(x) % $signed(y);
    end
    case (fn)
      rv_alu_pkg::ALU_ADD:    return x + y;
      rv_alu_pkg::ALU_SUB:    return x - y;
      rv_alu_pkg::ALU_SLL:    return x << y[4:0];
      rv_alu_pkg::ALU_SRL:    return x >> y[4:0];
      rv_alu_pkg::ALU_SRA:    return $signed(x) >>> y[4:0];
      rv_alu_pkg::ALU_OR:     return x | y;
      rv_alu_pkg::ALU_AND:    return x & y;
      rv_alu_pkg::ALU_XOR:    return x ^ y;
      rv_alu_pkg::ALU_SLT:    return {31'b0, $signed(x) < $signed(y)};
      rv_alu_pkg::ALU_SLTU:   return {31'b0, x < y};
      rv_alu_pkg::ALU_MUL:    return p_ss[31:0];
      rv_alu_pkg::ALU_MULH:   return p_ss[63:32];
      rv_alu_pkg::ALU_MULHSU: return p_su[63:32];
      rv_alu_pkg::ALU_MULHU:  return p_uu[63:32];
      rv_alu_pkg::ALU_DIV:    return (y == 0) ? 32'hffff_ffff : (ovf ? x : q_s);
      rv_alu_pkg::ALU_DIVU:   return (y == 0) ? 32'hffff_ffff : x / y;
      rv_alu_pkg::ALU_REM:    return (y == 0) ? x : (ovf ? 32'h0 : r_s);
      rv_alu_pkg::ALU_REMU:   return (y == 0) ? x : x % y;
      default:                return 32'h0;
    endcase
  endfunction

  function automatic logic ref_branch(rv_alu_pkg::br_cond_e cond, logic [31:0] x,
                                      logic [31:0] y);
    case (cond)
      rv_alu_pkg::BR_EQ:  return x == y;
      rv_alu_pkg::BR_NE:  return x != y;
      rv_alu_pkg::BR_LT:  return $signed(x) < $signed(y);
      rv_alu_pkg::BR_GE:  return $signed(x) >= $signed(y);
      rv_alu_pkg::BR_LTU: return x < y;
      rv_alu_pkg::BR_GEU: return x >= y;
      default:            return 1'b0;
    endcase
  endfunction

  task automatic report_mismatch(string what, logic [31:0] x, logic [31:0] y,
                                 logic [31:0] got, logic [31:0] exp);
    $display("ERR %0t: %s a=%h b=%h got %h expected %h", $time, what, x, y, got, exp);
    err_cnt++;
  endtask

  task automatic end_test(string name, int err_start, int ops);
    test_cnt++;
    if (err_cnt == err_start)
      $display("%s: ok, %0d ops", name, ops);
    else
      $display("%s: %0d errors in %0d ops", name, err_cnt - err_start, ops);
  endtask

  task automatic drive(logic [31:0] x, logic [31:0] y, rv_alu_pkg::alu_op_t o);
    @(negedge clk);
    a  = x;
    b  = y;
    op = o;
  endtask

  // Counts falling edges until done is seen and returns 0 if it never comes
  task automatic wait_done(output int cycles);
    int n;
    n      = 0;
    cycles = 0;
    while (cycles == 0 && n < DIV_LAT + 4)
    begin
      @(negedge clk);
      n++;
      if (done === 1'b1)
        cycles = n;
    end
    if (cycles == 0)
    begin
      $display("%0t: done never pulsed within %0d cycles", $time, DIV_LAT + 4);
      err_cnt++;
    end
  endtask

  task automatic run_multi(rv_alu_pkg::alu_fn_e fn, logic [31:0] x, logic [31:0] y, int lat);
    int          cycles;
    logic [31:0] exp;
    exp = ref_result(fn, x, y);
    drive(x, y, make_op(fn, 1'b0, rv_alu_pkg::BR_EQ));
    wait_done(cycles);
    if (cycles != 0 && cycles != lat)
    begin
      $display("ERR %0t: %s done after %0d cycles, expected %0d", $time, fn.name(), cycles, lat);
      err_cnt++;
    end
    if (cycles != 0 && result !== exp)
      report_mismatch(fn.name(), x, y, result, exp);
    drive('0, '0, idle_op());  // One idle cycle before the next op
  endtask

`include "tb_rv_alu_tests.svh"

  initial begin
    err_cnt  = 0;
    test_cnt = 0;
    rstn     = 1'b0;
    a        = '0;
    b        = '0;
    op       = idle_op();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    test_single();
    test_branch();
    test_mul();
    test_div();
    test_div_special();
    test_reset_pulse();
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_alu.f
+incdir+.
rv_alu_pkg.sv
alu_shifter.sv
alu_multiplier.sv
alu_divider.sv
rv_alu.sv
tb_rv_alu.sv

// File: Bender.yml
package:
  name: rv_alu

sources:
  - rv_alu_pkg.sv
  - alu_shifter.sv
  - alu_multiplier.sv
  - alu_divider.sv
  - rv_alu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_alu.sv
